// File: design/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Opcodes carried in ISR[15:10]
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_CLR = 6'b000100;
    localparam logic [5:0] OP_ASL = 6'b001000;
    localparam logic [5:0] OP_ASR = 6'b001001;
    localparam logic [5:0] OP_RLC = 6'b001010;
    localparam logic [5:0] OP_RRC = 6'b001011;
    localparam logic [5:0] OP_LSL = 6'b001100;
    localparam logic [5:0] OP_LSR = 6'b001101;
    localparam logic [5:0] OP_ROL = 6'b001110;
    localparam logic [5:0] OP_ROR = 6'b001111;
    localparam logic [5:0] OP_MOV = 6'b010000;
    localparam logic [5:0] OP_JMP = 6'b010001;
    localparam logic [5:0] OP_RET = 6'b010010;
    localparam logic [5:0] OP_ADD = 6'b010100;
    localparam logic [5:0] OP_RJP = 6'b010101;
    localparam logic [5:0] OP_ADC = 6'b010110;
    localparam logic [5:0] OP_SUB = 6'b011000;
    localparam logic [5:0] OP_SBC = 6'b011010;
    localparam logic [5:0] OP_CMP = 6'b011011;
    localparam logic [5:0] OP_OR  = 6'b100000;
    localparam logic [5:0] OP_XOR = 6'b100001;
    localparam logic [5:0] OP_AND = 6'b100010;
    localparam logic [5:0] OP_BIT = 6'b100011;
    localparam logic [5:0] OP_JSR = 6'b101100;
    localparam logic [5:0] OP_RJS = 6'b101101;
    localparam logic [5:0] OP_BRN = 6'b110000;
    localparam logic [5:0] OP_BRZ = 6'b110001;
    localparam logic [5:0] OP_BRV = 6'b110010;
    localparam logic [5:0] OP_BRC = 6'b110011;
    localparam logic [5:0] OP_RBN = 6'b111000;
    localparam logic [5:0] OP_RBZ = 6'b111001;
    localparam logic [5:0] OP_RBV = 6'b111010;
    localparam logic [5:0] OP_RBC = 6'b111011;

    localparam logic [1:0] MODE_D  = 2'b00;  // Register direct
    localparam logic [1:0] MODE_I  = 2'b01;  // Register indirect
    localparam logic [1:0] MODE_MI = 2'b10;  // Pre-decrement indirect
    localparam logic [1:0] MODE_IP = 2'b11;  // Post-increment indirect

    localparam int NUM_REGS  = 8;  // R6 is the stack pointer, R7 the PC
    localparam int REG_SEL_W = 3;

    //////////////////////////////////////////////////////////////////////
    // Inputs
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0]           ex_state;
        logic [1:0]           f_mode;
        logic [REG_SEL_W-1:0] f_value;
        logic [1:0]           t_mode;
        logic [REG_SEL_W-1:0] t_value;
    } isr_t;

    typedef struct packed {
        logic if0;
        logic if1;
        logic ff0;
        logic ff1;
        logic ff2;
        logic tf0;
        logic tf1;
        logic ex1;
    } phase_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } psw_t;

    //////////////////////////////////////////////////////////////////////
    // Decoded instruction class
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic op_clr;
        logic op_asl, op_asr, op_rlc, op_rrc;
        logic op_lsl, op_lsr, op_rol, op_ror;
        logic op_mov, op_jmp, op_ret;
        logic op_add, op_rjp, op_adc;
        logic op_sub, op_sbc, op_cmp;
        logic op_or, op_xor, op_and, op_bit;
        logic op_jsr, op_rjs;
        logic op_brn, op_brz, op_brv, op_brc;
        logic op_rbn, op_rbz, op_rbv, op_rbc;
    } op_flags_t;

    typedef struct packed {
        logic f_direct;
        logic f_ip;
        logic f_mi;
        logic t_direct;
        logic t_ip;
    } operand_mode_t;

    //////////////////////////////////////////////////////////////////////
    // Registered control outputs
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                mda;
        logic                b0b;
        logic                smd;
        logic                sma;
        logic                sb0;
        logic [NUM_REGS-1:0] rd_en;
        logic [NUM_REGS-1:0] wr_en;
    } reg_ctrl_t;

    typedef struct packed {
        logic als;
        logic alu_x;
        logic alu_y;
        logic alu_z;
        logic alu_u;
        logic alu_v;
        logic set_psw;
    } alu_ctrl_t;

    typedef struct packed {
        logic shs;
        logic sft_a;
        logic sft_b;
        logic sft_c;
        logic sft_d;
        logic sft_e;
        logic sft_r;
        logic sft_l;
    } shift_ctrl_t;

endpackage

`default_nettype wire

// File: design/instr_class_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_class_decode (
    input  wire cpu_ctrl_pkg::isr_t       isr,
    output cpu_ctrl_pkg::op_flags_t       op_flags,
    output cpu_ctrl_pkg::operand_mode_t   modes
);

    //////////////////////////////////////////////////////////////////////
    // Opcode table with at most one flag raised
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        op_flags.op_clr = (isr.ex_state == cpu_ctrl_pkg::OP_CLR);

        op_flags.op_asl = (isr.ex_state == cpu_ctrl_pkg::OP_ASL);
        op_flags.op_asr = (isr.ex_state == cpu_ctrl_pkg::OP_ASR);
        op_flags.op_rlc = (isr.ex_state == cpu_ctrl_pkg::OP_RLC);
        op_flags.op_rrc = (isr.ex_state == cpu_ctrl_pkg::OP_RRC);
        op_flags.op_lsl = (isr.ex_state == cpu_ctrl_pkg::OP_LSL);
        op_flags.op_lsr = (isr.ex_state == cpu_ctrl_pkg::OP_LSR);
        op_flags.op_rol = (isr.ex_state == cpu_ctrl_pkg::OP_ROL);
        op_flags.op_ror = (isr.ex_state == cpu_ctrl_pkg::OP_ROR);

        op_flags.op_mov = (isr.ex_state == cpu_ctrl_pkg::OP_MOV);
        op_flags.op_jmp = (isr.ex_state == cpu_ctrl_pkg::OP_JMP);
        op_flags.op_ret = (isr.ex_state == cpu_ctrl_pkg::OP_RET);

        op_flags.op_add = (isr.ex_state == cpu_ctrl_pkg::OP_ADD);
        op_flags.op_rjp = (isr.ex_state == cpu_ctrl_pkg::OP_RJP);
        op_flags.op_adc = (isr.ex_state == cpu_ctrl_pkg::OP_ADC);
        op_flags.op_sub = (isr.ex_state == cpu_ctrl_pkg::OP_SUB);
        op_flags.op_sbc = (isr.ex_state == cpu_ctrl_pkg::OP_SBC);
        op_flags.op_cmp = (isr.ex_state == cpu_ctrl_pkg::OP_CMP);

        op_flags.op_or  = (isr.ex_state == cpu_ctrl_pkg::OP_OR);
        op_flags.op_xor = (isr.ex_state == cpu_ctrl_pkg::OP_XOR);
        op_flags.op_and = (isr.ex_state == cpu_ctrl_pkg::OP_AND);
        op_flags.op_bit = (isr.ex_state == cpu_ctrl_pkg::OP_BIT);

        op_flags.op_jsr = (isr.ex_state == cpu_ctrl_pkg::OP_JSR);
        op_flags.op_rjs = (isr.ex_state == cpu_ctrl_pkg::OP_RJS);

        op_flags.op_brn = (isr.ex_state == cpu_ctrl_pkg::OP_BRN);
        op_flags.op_brz = (isr.ex_state == cpu_ctrl_pkg::OP_BRZ);
        op_flags.op_brv = (isr.ex_state == cpu_ctrl_pkg::OP_BRV);
        op_flags.op_brc = (isr.ex_state == cpu_ctrl_pkg::OP_BRC);
        op_flags.op_rbn = (isr.ex_state == cpu_ctrl_pkg::OP_RBN);
        op_flags.op_rbz = (isr.ex_state == cpu_ctrl_pkg::OP_RBZ);
        op_flags.op_rbv = (isr.ex_state == cpu_ctrl_pkg::OP_RBV);
        op_flags.op_rbc = (isr.ex_state == cpu_ctrl_pkg::OP_RBC);
    end

    //////////////////////////////////////////////////////////////////////
    // Addressing modes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        modes.f_direct = (isr.f_mode == cpu_ctrl_pkg::MODE_D);  // Plain indirect raises no flag
        modes.f_mi     = (isr.f_mode == cpu_ctrl_pkg::MODE_MI);
        modes.f_ip     = (isr.f_mode == cpu_ctrl_pkg::MODE_IP);

        // Only direct and post-increment matter on the to side
        modes.t_direct = (isr.t_mode == cpu_ctrl_pkg::MODE_D);
        modes.t_ip     = (isr.t_mode == cpu_ctrl_pkg::MODE_IP);
    end

endmodule

`default_nettype wire

// File: design/reg_select_decode.sv
`timescale 1ns/10ps
`default_nettype none

module reg_select_decode (
    input  wire                              clk,
    input  wire                              rst,
    input  wire cpu_ctrl_pkg::isr_t          isr,
    input  wire cpu_ctrl_pkg::phase_t        phase,
    input  wire cpu_ctrl_pkg::psw_t          psw,
    input  wire cpu_ctrl_pkg::op_flags_t     op_flags,
    input  wire cpu_ctrl_pkg::operand_mode_t modes,
    output cpu_ctrl_pkg::reg_ctrl_t          reg_ctrl
);

    localparam int PC_IDX = cpu_ctrl_pkg::NUM_REGS - 1;
    localparam int SP_IDX = cpu_ctrl_pkg::NUM_REGS - 2;

    logic shift_op;
    logic arith_op;
    logic logic_op;
    logic br_op;
    logic rb_op;
    logic wb_op;
    logic branch_taken;

    cpu_ctrl_pkg::reg_ctrl_t reg_ctrl_d;

    //////////////////////////////////////////////////////////////////////
    // Opcode groups
    //////////////////////////////////////////////////////////////////////

    assign shift_op = op_flags.op_asl | op_flags.op_asr | op_flags.op_rlc | op_flags.op_rrc |
                      op_flags.op_lsl | op_flags.op_lsr | op_flags.op_rol | op_flags.op_ror;

    assign arith_op = op_flags.op_add | op_flags.op_adc | op_flags.op_rjp |
                      op_flags.op_sub | op_flags.op_sbc | op_flags.op_cmp;

    assign logic_op = op_flags.op_or | op_flags.op_xor | op_flags.op_and | op_flags.op_bit;

    assign br_op = op_flags.op_brn | op_flags.op_brz | op_flags.op_brv | op_flags.op_brc;
    assign rb_op = op_flags.op_rbn | op_flags.op_rbz | op_flags.op_rbv | op_flags.op_rbc;

    // Results that land in the to-register
    assign wb_op = op_flags.op_clr | shift_op | op_flags.op_mov |
                   op_flags.op_add | op_flags.op_adc | op_flags.op_rjp |
                   op_flags.op_or | op_flags.op_xor | op_flags.op_and;

    // Absolute and relative branches test the same PSW flag
    assign branch_taken = (psw.n & (op_flags.op_brn | op_flags.op_rbn)) |
                          (psw.z & (op_flags.op_brz | op_flags.op_rbz)) |
                          (psw.v & (op_flags.op_brv | op_flags.op_rbv)) |
                          (psw.c & (op_flags.op_brc | op_flags.op_rbc));

    //////////////////////////////////////////////////////////////////////
    // Next selects
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        reg_ctrl_d = '0;

        for (int i = 0; i < cpu_ctrl_pkg::NUM_REGS; i++) begin
            reg_ctrl_d.rd_en[i] =
                (phase.ff0 & (isr.f_value == cpu_ctrl_pkg::REG_SEL_W'(i))) |
                (phase.ff1 & modes.f_ip & (isr.f_value == cpu_ctrl_pkg::REG_SEL_W'(i))) |
                (phase.tf0 & (isr.t_value == cpu_ctrl_pkg::REG_SEL_W'(i))) |
                (phase.tf1 & modes.t_ip & (isr.t_value == cpu_ctrl_pkg::REG_SEL_W'(i)));

            reg_ctrl_d.wr_en[i] =
                (phase.ff0 & (isr.f_value == cpu_ctrl_pkg::REG_SEL_W'(i))) |
                (phase.ff1 & modes.f_ip & (isr.f_value == cpu_ctrl_pkg::REG_SEL_W'(i))) |
                (phase.tf1 & modes.t_ip & (isr.t_value == cpu_ctrl_pkg::REG_SEL_W'(i))) |
                (wb_op & modes.t_direct & (isr.t_value == cpu_ctrl_pkg::REG_SEL_W'(i)));
        end

        reg_ctrl_d.rd_en[SP_IDX] = reg_ctrl_d.rd_en[SP_IDX] | op_flags.op_ret;
        reg_ctrl_d.rd_en[PC_IDX] = reg_ctrl_d.rd_en[PC_IDX] | phase.if0 | phase.if1 |
                                   (op_flags.op_rjs & phase.ex1);

        // PC update on fetch, jumps, taken branches and calls
        reg_ctrl_d.wr_en[PC_IDX] = reg_ctrl_d.wr_en[PC_IDX] | phase.if1 |
                                   op_flags.op_jmp | op_flags.op_ret | branch_taken |
                                   ((op_flags.op_jsr | op_flags.op_rjs) & phase.ex1);

        reg_ctrl_d.mda = phase.ff2 | shift_op | arith_op | logic_op | rb_op;
        reg_ctrl_d.b0b = op_flags.op_mov | op_flags.op_jmp | arith_op | logic_op |
                         op_flags.op_jsr | op_flags.op_rjs | br_op | rb_op | phase.ex1;
        reg_ctrl_d.smd = phase.if0 | phase.ff0 | phase.tf0 | op_flags.op_clr | shift_op |
                         op_flags.op_mov | op_flags.op_add | op_flags.op_adc |
                         op_flags.op_rjp | op_flags.op_sub | op_flags.op_sbc |
                         op_flags.op_or | op_flags.op_xor | op_flags.op_and |
                         op_flags.op_jsr | op_flags.op_rjs;
        reg_ctrl_d.sma = phase.if0 | phase.ff0 | phase.tf0;
        reg_ctrl_d.sb0 = phase.ff2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_ctrl <= '0;
        end else begin
            reg_ctrl <= reg_ctrl_d;
        end
    end

endmodule

`default_nettype wire

// File: design/alu_shift_decode.sv
`timescale 1ns/10ps
`default_nettype none

module alu_shift_decode (
    input  wire                              clk,
    input  wire                              rst,
    input  wire cpu_ctrl_pkg::phase_t        phase,
    input  wire cpu_ctrl_pkg::psw_t          psw,
    input  wire cpu_ctrl_pkg::op_flags_t     op_flags,
    input  wire cpu_ctrl_pkg::operand_mode_t modes,
    output cpu_ctrl_pkg::alu_ctrl_t          alu_ctrl,
    output cpu_ctrl_pkg::shift_ctrl_t        shift_ctrl
);

    logic shift_op;
    logic arith_op;
    logic logic_op;
    logic br_op;
    logic rb_op;
    logic pass_b;

    cpu_ctrl_pkg::alu_ctrl_t   alu_ctrl_d;
    cpu_ctrl_pkg::shift_ctrl_t shift_ctrl_d;

    assign shift_op = op_flags.op_asl | op_flags.op_asr | op_flags.op_rlc | op_flags.op_rrc |
                      op_flags.op_lsl | op_flags.op_lsr | op_flags.op_rol | op_flags.op_ror;

    assign arith_op = op_flags.op_add | op_flags.op_adc | op_flags.op_rjp |
                      op_flags.op_sub | op_flags.op_sbc | op_flags.op_cmp;

    assign logic_op = op_flags.op_or | op_flags.op_xor | op_flags.op_and | op_flags.op_bit;

    assign br_op = op_flags.op_brn | op_flags.op_brz | op_flags.op_brv | op_flags.op_brc;
    assign rb_op = op_flags.op_rbn | op_flags.op_rbz | op_flags.op_rbv | op_flags.op_rbc;

    // Terms shared by alu_y and alu_v, note ff1 is absent
    assign pass_b = phase.if0 | phase.if1 | phase.ff0 | phase.ff2 | phase.tf0 | phase.tf1 |
                    phase.ex1 | op_flags.op_mov | op_flags.op_jmp | op_flags.op_ret |
                    arith_op | op_flags.op_jsr | op_flags.op_rjs | br_op;

    //////////////////////////////////////////////////////////////////////
    // ALU function lines
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_ctrl_d.als     = (|phase) | op_flags.op_clr | op_flags.op_mov | op_flags.op_jmp |
                             op_flags.op_ret | arith_op | logic_op | op_flags.op_jsr |
                             op_flags.op_rjs | br_op | rb_op;
        alu_ctrl_d.alu_x   = (phase.ff0 & modes.f_mi) | op_flags.op_sub | op_flags.op_sbc |
                             op_flags.op_cmp;
        alu_ctrl_d.alu_y   = pass_b;
        alu_ctrl_d.alu_z   = op_flags.op_or | rb_op;
        alu_ctrl_d.alu_u   = phase.if1 | phase.tf1 | op_flags.op_sub | op_flags.op_cmp |
                             (psw.c & (op_flags.op_adc | op_flags.op_sbc));  // Carry in
        alu_ctrl_d.alu_v   = pass_b | op_flags.op_xor | rb_op;
        alu_ctrl_d.set_psw = op_flags.op_clr | shift_op | op_flags.op_mov | op_flags.op_add |
                             op_flags.op_adc | op_flags.op_sub | op_flags.op_sbc |
                             op_flags.op_cmp | logic_op;
    end

    //////////////////////////////////////////////////////////////////////
    // Shifter lines
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        shift_ctrl_d.shs   = shift_op;
        shift_ctrl_d.sft_a = op_flags.op_asr;  // Sign fill
        shift_ctrl_d.sft_b = op_flags.op_rol;
        shift_ctrl_d.sft_c = op_flags.op_lsr | op_flags.op_rol | op_flags.op_rlc;
        shift_ctrl_d.sft_d = op_flags.op_ror;
        shift_ctrl_d.sft_e = op_flags.op_rlc | op_flags.op_rrc;  // Rotate through carry
        shift_ctrl_d.sft_r = op_flags.op_asr | op_flags.op_ror | op_flags.op_rrc;
        shift_ctrl_d.sft_l = op_flags.op_asr | op_flags.op_lsr | op_flags.op_rol |
                             op_flags.op_rlc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_ctrl   <= '0;
            shift_ctrl <= '0;
        end else begin
            alu_ctrl   <= alu_ctrl_d;
            shift_ctrl <= shift_ctrl_d;
        end
    end

endmodule

`default_nettype wire

// File: design/ctrl_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_decoder (
    input  wire                       clk,
    input  wire                       rst,
    input  wire cpu_ctrl_pkg::isr_t   isr,
    input  wire cpu_ctrl_pkg::phase_t phase,
    input  wire cpu_ctrl_pkg::psw_t   psw,
    output cpu_ctrl_pkg::reg_ctrl_t   reg_ctrl,
    output cpu_ctrl_pkg::alu_ctrl_t   alu_ctrl,
    output cpu_ctrl_pkg::shift_ctrl_t shift_ctrl
);

    cpu_ctrl_pkg::op_flags_t     op_flags;
    cpu_ctrl_pkg::operand_mode_t modes;

    //////////////////////////////////////////////////////////////////////
    // Shared instruction class, combinational
    //////////////////////////////////////////////////////////////////////

    instr_class_decode i_instr_class_decode (
        .isr      (isr),
        .op_flags (op_flags),
        .modes    (modes)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath decoders, one register stage each
    //////////////////////////////////////////////////////////////////////

    reg_select_decode i_reg_select_decode (
        .clk      (clk),
        .rst      (rst),
        .isr      (isr),
        .phase    (phase),
        .psw      (psw),
        .op_flags (op_flags),
        .modes    (modes),
        .reg_ctrl (reg_ctrl)
    );

    alu_shift_decode i_alu_shift_decode (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .psw        (psw),
        .op_flags   (op_flags),
        .modes      (modes),
        .alu_ctrl   (alu_ctrl),
        .shift_ctrl (shift_ctrl)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;  // 10 ns period
        end
    end

endmodule

`default_nettype wire

// File: dv/ctrl_decoder_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_decoder_asserts (
    input wire                            clk,
    input wire                            rst,
    input wire cpu_ctrl_pkg::reg_ctrl_t   reg_ctrl,
    input wire cpu_ctrl_pkg::alu_ctrl_t   alu_ctrl,
    input wire cpu_ctrl_pkg::shift_ctrl_t shift_ctrl
);

    // Every address load also routes the data bus
    sma_implies_smd: assert property (@(posedge clk) disable iff (rst)
        reg_ctrl.sma |-> reg_ctrl.smd)
        else $error("sma is set while smd is clear");

    shs_implies_set_psw: assert property (@(posedge clk) disable iff (rst)
        shift_ctrl.shs |-> alu_ctrl.set_psw)
        else $error("shs is set while set_psw is clear");

    // OR and the relative branches both take the A operand from the data bus
    alu_z_implies_mda: assert property (@(posedge clk) disable iff (rst)
        alu_ctrl.alu_z |-> reg_ctrl.mda)
        else $error("alu_z is set while mda is clear");

    reset_clears_outputs: assert property (@(posedge clk)
        rst |=> (reg_ctrl == '0) && (alu_ctrl == '0) && (shift_ctrl == '0))
        else $error("outputs are not all zero after a reset edge");

endmodule

`default_nettype wire

// File: dv/ctrl_decoder_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_decoder_tb;

    localparam int RESET_CYCLES  = 8;
    localparam int NUM_ITEMS     = 2000;
    localparam int CLK_PERIOD_NS = 10;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + NUM_ITEMS + 20) * CLK_PERIOD_NS;

    localparam logic [31:0][5:0] OPCODES = {
        cpu_ctrl_pkg::OP_CLR, cpu_ctrl_pkg::OP_ASL, cpu_ctrl_pkg::OP_ASR, cpu_ctrl_pkg::OP_RLC,
        cpu_ctrl_pkg::OP_RRC, cpu_ctrl_pkg::OP_LSL, cpu_ctrl_pkg::OP_LSR, cpu_ctrl_pkg::OP_ROL,
        cpu_ctrl_pkg::OP_ROR, cpu_ctrl_pkg::OP_MOV, cpu_ctrl_pkg::OP_JMP, cpu_ctrl_pkg::OP_RET,
        cpu_ctrl_pkg::OP_ADD, cpu_ctrl_pkg::OP_RJP, cpu_ctrl_pkg::OP_ADC, cpu_ctrl_pkg::OP_SUB,
        cpu_ctrl_pkg::OP_SBC, cpu_ctrl_pkg::OP_CMP, cpu_ctrl_pkg::OP_OR,  cpu_ctrl_pkg::OP_XOR,
        cpu_ctrl_pkg::OP_AND, cpu_ctrl_pkg::OP_BIT, cpu_ctrl_pkg::OP_JSR, cpu_ctrl_pkg::OP_RJS,
        cpu_ctrl_pkg::OP_BRN, cpu_ctrl_pkg::OP_BRZ, cpu_ctrl_pkg::OP_BRV, cpu_ctrl_pkg::OP_BRC,
        cpu_ctrl_pkg::OP_RBN, cpu_ctrl_pkg::OP_RBZ, cpu_ctrl_pkg::OP_RBV, cpu_ctrl_pkg::OP_RBC
    };

    logic                      clk;
    logic                      rst;
    cpu_ctrl_pkg::isr_t        isr;
    cpu_ctrl_pkg::phase_t      phase;
    cpu_ctrl_pkg::psw_t        psw;
    cpu_ctrl_pkg::reg_ctrl_t   reg_ctrl;
    cpu_ctrl_pkg::alu_ctrl_t   alu_ctrl;
    cpu_ctrl_pkg::shift_ctrl_t shift_ctrl;

    logic                      prev_rst;  // Inputs sampled at the coming edge
    cpu_ctrl_pkg::isr_t        prev_isr;
    cpu_ctrl_pkg::phase_t      prev_phase;
    cpu_ctrl_pkg::psw_t        prev_psw;
    logic [31:0]               rng_state;
    int                        errors;
    int                        checks;

    tb_clock_gen i_tb_clock_gen (
        .clk (clk)
    );

    ctrl_decoder i_ctrl_decoder (
        .clk        (clk),
        .rst        (rst),
        .isr        (isr),
        .phase      (phase),
        .psw        (psw),
        .reg_ctrl   (reg_ctrl),
        .alu_ctrl   (alu_ctrl),
        .shift_ctrl (shift_ctrl)
    );

    bind ctrl_decoder ctrl_decoder_asserts i_ctrl_decoder_asserts (
        .clk        (clk),
        .rst        (rst),
        .reg_ctrl   (reg_ctrl),
        .alu_ctrl   (alu_ctrl),
        .shift_ctrl (shift_ctrl)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model of the control rules
    //////////////////////////////////////////////////////////////////////

    task automatic model_outputs(
        input  cpu_ctrl_pkg::isr_t        x,
        input  cpu_ctrl_pkg::phase_t      p,
        input  cpu_ctrl_pkg::psw_t        s,
        output cpu_ctrl_pkg::reg_ctrl_t   r_exp,
        output cpu_ctrl_pkg::alu_ctrl_t   a_exp,
        output cpu_ctrl_pkg::shift_ctrl_t s_exp
    );
        logic [5:0] op;
        logic shift, arith, lgc, br, rb, wb, flag, taken, pass_b;
        logic clr, mov, jmp, ret, add, adc, rjp, sub, sbc, cmp;
        logic o_or, o_xor, o_and, jsr, rjs;
        logic asr, rlc, rrc, lsr, rol, ror;
        logic f_ip, f_mi, t_dir, t_ip, f_hit, t_hit;
        op    = x.ex_state;
        shift = (op[5:3] == 3'b001);  // All eight codes 001xxx are shifts
        lgc   = (op[5:2] == 4'b1000);
        br    = (op[5:2] == 4'b1100);
        rb    = (op[5:2] == 4'b1110);
        clr   = (op == cpu_ctrl_pkg::OP_CLR);
        mov   = (op == cpu_ctrl_pkg::OP_MOV);
        jmp   = (op == cpu_ctrl_pkg::OP_JMP);
        ret   = (op == cpu_ctrl_pkg::OP_RET);
        add   = (op == cpu_ctrl_pkg::OP_ADD);
        adc   = (op == cpu_ctrl_pkg::OP_ADC);
        rjp   = (op == cpu_ctrl_pkg::OP_RJP);
        sub   = (op == cpu_ctrl_pkg::OP_SUB);
        sbc   = (op == cpu_ctrl_pkg::OP_SBC);
        cmp   = (op == cpu_ctrl_pkg::OP_CMP);
        o_or  = (op == cpu_ctrl_pkg::OP_OR);
        o_xor = (op == cpu_ctrl_pkg::OP_XOR);
        o_and = (op == cpu_ctrl_pkg::OP_AND);
        jsr   = (op == cpu_ctrl_pkg::OP_JSR);
        rjs   = (op == cpu_ctrl_pkg::OP_RJS);
        asr   = (op == cpu_ctrl_pkg::OP_ASR);
        rlc   = (op == cpu_ctrl_pkg::OP_RLC);
        rrc   = (op == cpu_ctrl_pkg::OP_RRC);
        lsr   = (op == cpu_ctrl_pkg::OP_LSR);
        rol   = (op == cpu_ctrl_pkg::OP_ROL);
        ror   = (op == cpu_ctrl_pkg::OP_ROR);
        arith = add | adc | rjp | sub | sbc | cmp;
        wb    = clr | shift | mov | add | adc | rjp | o_or | o_xor | o_and;
        f_ip  = (x.f_mode == cpu_ctrl_pkg::MODE_IP);
        f_mi  = (x.f_mode == cpu_ctrl_pkg::MODE_MI);
        t_dir = (x.t_mode == cpu_ctrl_pkg::MODE_D);
        t_ip  = (x.t_mode == cpu_ctrl_pkg::MODE_IP);

        case (op[1:0])  // Branch condition order is N, Z, V, C
            2'b00:   flag = s.n;
            2'b01:   flag = s.z;
            2'b10:   flag = s.v;
            default: flag = s.c;
        endcase
        taken = (br | rb) & flag;

        r_exp = '0;
        for (int r = 0; r < cpu_ctrl_pkg::NUM_REGS; r++) begin
            f_hit = (x.f_value == 3'(r));
            t_hit = (x.t_value == 3'(r));
            r_exp.rd_en[r] = (p.ff0 & f_hit) | (p.ff1 & f_ip & f_hit) |
                             (p.tf0 & t_hit) | (p.tf1 & t_ip & t_hit);
            r_exp.wr_en[r] = (p.ff0 & f_hit) | (p.ff1 & f_ip & f_hit) |
                             (p.tf1 & t_ip & t_hit) | (wb & t_dir & t_hit);
        end
        r_exp.rd_en[6] = r_exp.rd_en[6] | ret;
        r_exp.rd_en[7] = r_exp.rd_en[7] | p.if0 | p.if1 | (rjs & p.ex1);
        r_exp.wr_en[7] = r_exp.wr_en[7] | p.if1 | jmp | ret | taken | ((jsr | rjs) & p.ex1);
        r_exp.mda = p.ff2 | shift | arith | lgc | rb;
        r_exp.b0b = mov | jmp | arith | lgc | jsr | rjs | br | rb | p.ex1;
        r_exp.smd = p.if0 | p.ff0 | p.tf0 | clr | shift | mov | add | adc | rjp | sub | sbc |
                    o_or | o_xor | o_and | jsr | rjs;
        r_exp.sma = p.if0 | p.ff0 | p.tf0;
        r_exp.sb0 = p.ff2;

        pass_b = p.if0 | p.if1 | p.ff0 | p.ff2 | p.tf0 | p.tf1 | p.ex1 | mov | jmp | ret |
                 arith | jsr | rjs | br;
        a_exp.als     = (|p) | clr | mov | jmp | ret | arith | lgc | jsr | rjs | br | rb;
        a_exp.alu_x   = (p.ff0 & f_mi) | sub | sbc | cmp;
        a_exp.alu_y   = pass_b;
        a_exp.alu_z   = o_or | rb;
        a_exp.alu_u   = p.if1 | p.tf1 | sub | cmp | (s.c & (adc | sbc));
        a_exp.alu_v   = pass_b | o_xor | rb;
        a_exp.set_psw = clr | shift | mov | add | adc | sub | sbc | cmp | lgc;

        s_exp.shs   = shift;
        s_exp.sft_a = asr;
        s_exp.sft_b = rol;
        s_exp.sft_c = lsr | rol | rlc;
        s_exp.sft_d = ror;
        s_exp.sft_e = rlc | rrc;
        s_exp.sft_r = asr | ror | rrc;
        s_exp.sft_l = asr | lsr | rol | rlc;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////////////////////////

    task automatic compare_field(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        cpu_ctrl_pkg::reg_ctrl_t   r_exp;
        cpu_ctrl_pkg::alu_ctrl_t   a_exp;
        cpu_ctrl_pkg::shift_ctrl_t s_exp;
        if (prev_rst) begin
            r_exp = '0;
            a_exp = '0;
            s_exp = '0;
        end else begin
            model_outputs(prev_isr, prev_phase, prev_psw, r_exp, a_exp, s_exp);
        end
        compare_field("rd_en", reg_ctrl.rd_en, r_exp.rd_en);
        compare_field("wr_en", reg_ctrl.wr_en, r_exp.wr_en);
        compare_field("mda", 8'(reg_ctrl.mda), 8'(r_exp.mda));
        compare_field("b0b", 8'(reg_ctrl.b0b), 8'(r_exp.b0b));
        compare_field("smd", 8'(reg_ctrl.smd), 8'(r_exp.smd));
        compare_field("sma", 8'(reg_ctrl.sma), 8'(r_exp.sma));
        compare_field("sb0", 8'(reg_ctrl.sb0), 8'(r_exp.sb0));
        compare_field("alu_ctrl", 8'(alu_ctrl), 8'(a_exp));
        compare_field("shift_ctrl", 8'(shift_ctrl), 8'(s_exp));
    endtask

    task automatic drive_random();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [5:0]  code;
        int          sel;
        rng_state = xorshift32(rng_state);
        r1 = rng_state;
        rng_state = xorshift32(rng_state);
        r2 = rng_state;
        if (r1[1:0] != 2'b00) begin
            code = OPCODES[r1[6:2]];
        end else begin
            code = r1[12:7];  // Any code, listed or not
        end
        sel = int'(r1[31:16] % 16'd9);
        if (sel == 8) begin
            phase = '0;
        end else begin
            phase = cpu_ctrl_pkg::phase_t'(8'b1 << sel);
        end
        isr = cpu_ctrl_pkg::isr_t'({code, r2[9:0]});
        psw = cpu_ctrl_pkg::psw_t'(r2[13:10]);
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        rng_state  = 32'd9;
        rst        = 1'b1;
        isr        = '0;
        phase      = '0;
        psw        = '0;
        prev_rst   = 1'b1;
        prev_isr   = '0;
        prev_phase = '0;
        prev_psw   = '0;
        for (int c = 0; c < RESET_CYCLES + NUM_ITEMS + 1; c++) begin
            @(posedge clk);
            #1;
            check_outputs();
            if (c + 1 < RESET_CYCLES) begin
                rst = 1'b1;
            end else begin
                rst = 1'b0;
                drive_random();  // A new item every cycle
            end
            prev_rst   = rst;
            prev_isr   = isr;
            prev_phase = phase;
            prev_psw   = psw;
        end
        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/cpu_ctrl_pkg.sv
design/instr_class_decode.sv
design/reg_select_decode.sv
design/alu_shift_decode.sv
design/ctrl_decoder.sv
dv/tb_clock_gen.sv
dv/ctrl_decoder_asserts.sv
dv/ctrl_decoder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module ctrl_decoder_tb \
    -o ctrl_decoder_sim || exit 1
sim_out="$(./obj_dir/ctrl_decoder_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "All checks passed" && exit 0 || exit 1
